// File: include/mipsBus_defines.svh
`ifndef MIPSBUS_DEFINES_SVH
`define MIPSBUS_DEFINES_SVH

// First fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Fetching from here stops the core
`define MIPS_HALT_ADDRESS 32'h00000000

`define MIPS_WORD_WIDTH 32

`define MIPS_REG_COUNT 32

`endif

// File: source/mipsPkg.sv
`include "mipsBus_defines.svh"

package mipsPkg;

    typedef logic [`MIPS_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddr_t;
    typedef logic [`MIPS_WORD_WIDTH-1:0] instr_t;
    typedef logic [4:0] shamt_t;

    // Only the opcodes this core executes
    typedef enum logic [5:0] {
        OpRType = 6'b000000,
        OpJ     = 6'b000010,
        OpBeq   = 6'b000100,
        OpBne   = 6'b000101,
        OpAddiu = 6'b001001,
        OpSlti  = 6'b001010,
        OpSltiu = 6'b001011,
        OpAndi  = 6'b001100,
        OpOri   = 6'b001101,
        OpXori  = 6'b001110,
        OpLui   = 6'b001111,
        OpLw    = 6'b100011,
        OpSw    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        FuncSll  = 6'b000000,
        FuncSrl  = 6'b000010,
        FuncSra  = 6'b000011,
        FuncSllv = 6'b000100,
        FuncSrlv = 6'b000110,
        FuncSrav = 6'b000111,
        FuncJr   = 6'b001000,
        FuncAddu = 6'b100001,
        FuncSubu = 6'b100011,
        FuncAnd  = 6'b100100,
        FuncOr   = 6'b100101,
        FuncXor  = 6'b100110,
        FuncSlt  = 6'b101010,
        FuncSltu = 6'b101011
    } func_t;

    typedef enum logic [3:0] {
        AluAnd, AluOr, AluXor, AluAdd, AluSub, AluSlt, AluSltu, AluSll,
        AluSrl, AluSra, AluSllv, AluSrlv, AluSrav, AluLui, AluPassA
    } aluOp_t;

    typedef enum logic [2:0] {
        StateFetch, StateDecode, StateExecute, StateMemory, StateWriteBack, StateHalted
    } cpuState_t;

    typedef enum logic [1:0] {
        AccessNone, AccessLoad, AccessStore
    } accessKind_t;

    typedef enum logic [2:0] {
        BranchNone, BranchBeq, BranchBne, BranchJump, BranchJumpReg
    } branchKind_t;

endpackage

// File: source/mipsRegisterFile.sv
`include "mipsBus_defines.svh"

module mipsRegisterFile (
    input  logic clk,
    input  logic reset,
    input  logic writeEnable,
    input  mipsPkg::regAddr_t writeAddr,
    input  mipsPkg::word_t writeData,
    input  mipsPkg::regAddr_t readAddrA,
    input  mipsPkg::regAddr_t readAddrB,
    output mipsPkg::word_t readDataA,
    output mipsPkg::word_t readDataB,
    output mipsPkg::word_t registerV0
);
    import mipsPkg::*;

    word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // $zero keeps its reset value
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    assign registerV0 = regs[2];

    // Even right after a write aimed at it
    zeroRegister: assert property (@(posedge clk) disable iff (reset)
        (readAddrA == '0 |-> readDataA == '0) and (readAddrB == '0 |-> readDataB == '0));

endmodule

// File: source/mipsAlu.sv
module mipsAlu (
    input  mipsPkg::aluOp_t op,
    input  mipsPkg::word_t a,
    input  mipsPkg::word_t b,
    input  mipsPkg::shamt_t shamt,
    output mipsPkg::word_t result,
    output logic zero
);
    import mipsPkg::*;

    shamt_t varShift;

    // Variable shifts take the amount from rs
    assign varShift = a[4:0];

    always_comb begin
        case (op)
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluSlt:  result = word_t'($signed(a) < $signed(b));
            AluSltu: result = word_t'(a < b);

            // Fixed shifts act on rt by the instruction's shamt
            AluSll:  result = b << shamt;
            AluSrl:  result = b >> shamt;
            AluSra:  result = word_t'($signed(b) >>> shamt);

            AluSllv: result = b << varShift;
            AluSrlv: result = b >> varShift;
            AluSrav: result = word_t'($signed(b) >>> varShift);

            AluLui:  result = {b[15:0], 16'h0000};
            AluPassA: result = a;
            default: result = a;
        endcase
    end

    // Branch compare
    assign zero = (result == '0);

endmodule

// File: source/mipsDecoder.sv
module mipsDecoder (
    input  mipsPkg::instr_t instr,
    output mipsPkg::aluOp_t aluOp,
    output logic useImmediate,
    output logic zeroExtend,
    output mipsPkg::regAddr_t destReg,
    output logic regWrite,
    output mipsPkg::accessKind_t accessKind,
    output mipsPkg::branchKind_t branchKind
);
    import mipsPkg::*;

    opcode_t opcode;
    func_t func;
    regAddr_t rt;
    regAddr_t rd;

    assign opcode = opcode_t'(instr[31:26]);
    assign func = func_t'(instr[5:0]);
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        // Defaults suit the immediate ALU forms
        aluOp = AluPassA;
        useImmediate = 1'b1;
        zeroExtend = 1'b0;
        destReg = rt;
        regWrite = 1'b1;
        accessKind = AccessNone;
        branchKind = BranchNone;

        case (opcode)
            OpRType: begin
                useImmediate = 1'b0;
                destReg = rd;
                case (func)
                    FuncSll:  aluOp = AluSll;
                    FuncSrl:  aluOp = AluSrl;
                    FuncSra:  aluOp = AluSra;
                    FuncSllv: aluOp = AluSllv;
                    FuncSrlv: aluOp = AluSrlv;
                    FuncSrav: aluOp = AluSrav;
                    FuncAddu: aluOp = AluAdd;
                    FuncSubu: aluOp = AluSub;
                    FuncAnd:  aluOp = AluAnd;
                    FuncOr:   aluOp = AluOr;
                    FuncXor:  aluOp = AluXor;
                    FuncSlt:  aluOp = AluSlt;
                    FuncSltu: aluOp = AluSltu;
                    FuncJr: begin
                        regWrite = 1'b0;
                        branchKind = BranchJumpReg;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            OpAddiu: aluOp = AluAdd;
            OpSlti:  aluOp = AluSlt;
            OpSltiu: aluOp = AluSltu;
            OpLui:   aluOp = AluLui;
            OpAndi: begin
                aluOp = AluAnd;
                zeroExtend = 1'b1;
            end
            OpOri: begin
                aluOp = AluOr;
                zeroExtend = 1'b1;
            end
            OpXori: begin
                aluOp = AluXor;
                zeroExtend = 1'b1;
            end
            OpLw: begin
                aluOp = AluAdd;
                accessKind = AccessLoad;
            end
            OpSw: begin
                aluOp = AluAdd;
                regWrite = 1'b0;
                accessKind = AccessStore;
            end
            // rs minus rt, zero flag decides
            OpBeq, OpBne: begin
                aluOp = AluSub;
                useImmediate = 1'b0;
                regWrite = 1'b0;
                branchKind = (opcode == OpBeq) ? BranchBeq : BranchBne;
            end
            OpJ: begin
                regWrite = 1'b0;
                branchKind = BranchJump;
            end
            default: regWrite = 1'b0;
        endcase
    end

endmodule

// File: source/mipsControl.sv
`include "mipsBus_defines.svh"

module mipsControl (
    input  logic clk,
    input  logic reset,
    input  logic waitRequest,
    input  mipsPkg::word_t readData,
    output mipsPkg::word_t address,
    output logic read,
    output logic write,
    output mipsPkg::word_t writeData,
    output logic [3:0] byteEnable,
    output logic active,
    output mipsPkg::instr_t instr,
    input  mipsPkg::aluOp_t aluOp,
    input  logic useImmediate,
    input  logic zeroExtend,
    input  mipsPkg::regAddr_t destReg,
    input  logic regWrite,
    input  mipsPkg::accessKind_t accessKind,
    input  mipsPkg::branchKind_t branchKind,
    input  mipsPkg::word_t readDataA,
    input  mipsPkg::word_t readDataB,
    input  mipsPkg::word_t aluResult,
    input  logic aluZero,
    output mipsPkg::regAddr_t regReadAddrA,
    output mipsPkg::regAddr_t regReadAddrB,
    output logic regWriteEnable,
    output mipsPkg::regAddr_t regWriteAddr,
    output mipsPkg::word_t regWriteData,
    output mipsPkg::word_t aluA,
    output mipsPkg::word_t aluB
);
    import mipsPkg::*;

    cpuState_t state;
    word_t pc;
    word_t pcPlus4;
    word_t immediate;
    word_t nextTarget;
    word_t branchTarget;
    logic branchTaken;
    // 0 idle, 1 branch resolved, 2 delay slot in flight
    logic [1:0] branchStep;

    assign pcPlus4 = pc + 32'd4;
    assign immediate = zeroExtend ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        branchTaken = 1'b0;
        nextTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        case (branchKind)
            BranchBeq: branchTaken = aluZero;
            BranchBne: branchTaken = !aluZero;
            BranchJump: begin
                branchTaken = 1'b1;
                nextTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
            end
            BranchJumpReg: begin
                branchTaken = 1'b1;
                nextTarget = aluA;
            end
            default: branchTaken = 1'b0;
        endcase
    end

    // Bus strobes, held until waitRequest drops
    assign read = (state == StateFetch && pc != `MIPS_HALT_ADDRESS)
        || (state == StateMemory && accessKind == AccessLoad);
    assign write = (state == StateMemory && accessKind == AccessStore);
    assign address = (state == StateMemory) ? aluResult : pc;
    assign writeData = readDataB;
    assign byteEnable = (read || write) ? 4'b1111 : 4'b0000;

    assign regReadAddrA = instr[25:21];
    assign regReadAddrB = instr[20:16];
    assign regWriteEnable = (state == StateWriteBack) && regWrite;
    assign regWriteAddr = destReg;
    assign regWriteData = (accessKind == AccessLoad) ? readData : aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= StateFetch;
            pc <= `MIPS_RESET_VECTOR;
            active <= 1'b1;
            branchStep <= 2'd0;
        end else begin
            case (state)
                StateFetch: begin
                    if (pc == `MIPS_HALT_ADDRESS) begin
                        active <= 1'b0;
                        state <= StateHalted;
                    end else if (!waitRequest) begin
                        state <= StateDecode;
                    end
                end
                StateDecode: state <= StateExecute;
                StateExecute: state <= StateMemory;
                StateMemory: begin
                    if (accessKind == AccessNone || !waitRequest) begin
                        state <= StateWriteBack;
                    end
                    if (branchTaken) begin
                        branchStep <= 2'd1;
                    end
                end
                StateWriteBack: begin
                    state <= StateFetch;
                    if (branchStep == 2'd2) begin
                        pc <= branchTarget;
                        branchStep <= 2'd0;
                    end else begin
                        pc <= pcPlus4;
                        if (branchStep == 2'd1) begin
                            branchStep <= 2'd2;
                        end
                    end
                end
                default: state <= StateHalted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Memory presents the word the cycle after the accept
        if (state == StateDecode) begin
            instr <= readData;
        end
        if (state == StateExecute) begin
            aluA <= readDataA;
            aluB <= useImmediate ? immediate : readDataB;
        end
        if (state == StateMemory && branchTaken) begin
            branchTarget <= nextTarget;
        end
    end

    noReadWithWrite: assert property (@(posedge clk) disable iff (reset) !(read && write));

    haltIsFinal: assert property (@(posedge clk) disable iff (reset)
        state == StateHalted |=> state == StateHalted && !read && !write);

    // Loads and stores form their address with the adder
    accessUsesAdd: assert property (@(posedge clk) disable iff (reset)
        (state == StateMemory && accessKind != AccessNone) |-> aluOp == AluAdd);

endmodule

// File: source/mipsBus.sv
module mipsBus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output mipsPkg::word_t registerV0,
    output mipsPkg::word_t address,
    output logic write,
    output logic read,
    input  logic waitRequest,
    output mipsPkg::word_t writeData,
    output logic [3:0] byteEnable,
    input  mipsPkg::word_t readData
);
    import mipsPkg::*;

    instr_t instr;
    aluOp_t aluOp;
    logic useImmediate;
    logic zeroExtend;
    regAddr_t destReg;
    logic regWrite;
    accessKind_t accessKind;
    branchKind_t branchKind;
    word_t readDataA;
    word_t readDataB;
    word_t aluA;
    word_t aluB;
    word_t aluResult;
    logic aluZero;
    regAddr_t regReadAddrA;
    regAddr_t regReadAddrB;
    logic regWriteEnable;
    regAddr_t regWriteAddr;
    word_t regWriteData;

    mipsControl control_i (
        .clk(clk), .reset(reset), .waitRequest(waitRequest), .readData(readData),
        .address(address), .read(read), .write(write), .writeData(writeData),
        .byteEnable(byteEnable), .active(active), .instr(instr), .aluOp(aluOp),
        .useImmediate(useImmediate), .zeroExtend(zeroExtend), .destReg(destReg),
        .regWrite(regWrite), .accessKind(accessKind), .branchKind(branchKind),
        .readDataA(readDataA), .readDataB(readDataB), .aluResult(aluResult),
        .aluZero(aluZero), .regReadAddrA(regReadAddrA), .regReadAddrB(regReadAddrB),
        .regWriteEnable(regWriteEnable), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .aluA(aluA), .aluB(aluB)
    );

    mipsDecoder decoder_i (
        .instr(instr), .aluOp(aluOp), .useImmediate(useImmediate),
        .zeroExtend(zeroExtend), .destReg(destReg), .regWrite(regWrite),
        .accessKind(accessKind), .branchKind(branchKind)
    );

    mipsRegisterFile registerFile_i (
        .clk(clk), .reset(reset), .writeEnable(regWriteEnable), .writeAddr(regWriteAddr),
        .writeData(regWriteData), .readAddrA(regReadAddrA), .readAddrB(regReadAddrB),
        .readDataA(readDataA), .readDataB(readDataB), .registerV0(registerV0)
    );

    // Shift amount comes straight from the held instruction
    mipsAlu alu_i (
        .op(aluOp), .a(aluA), .b(aluB), .shamt(instr[10:6]),
        .result(aluResult), .zero(aluZero)
    );

endmodule

// File: tests/clockGen.sv
module clockGen (
    input  logic resetRequest,
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    int resetCount;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        resetCount = 0;
    end

    // Five rising edges of reset, again on each request
    always @(posedge clk) begin
        if (resetRequest) begin
            reset <= 1'b1;
            resetCount <= 0;
        end else if (reset) begin
            if (resetCount == 4) begin
                reset <= 1'b0;
            end
            resetCount <= resetCount + 1;
        end
    end

endmodule

// File: tests/mipsBusTb.sv
`include "mipsBus_defines.svh"

module mipsBusTb;
    timeunit 1ns;
    timeprecision 100ps;

    import mipsPkg::*;

    localparam int QuietCycles = 20;
    localparam int ResetOverhead = 12;

    logic clk;
    logic reset;
    logic resetRequest = 1'b0;
    logic active;
    word_t registerV0;
    word_t address;
    logic write;
    logic read;
    logic waitRequest;
    word_t writeData;
    logic [3:0] byteEnable;
    word_t readData = '0;

    logic stallMode = 1'b0;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    // Stimulus as read from the file
    string testNames[$];
    word_t expectedV0[$];
    int memTest[$];
    word_t memAddr[$];
    word_t memData[$];
    int storeTest[$];
    word_t storeAddr[$];
    word_t storeData[$];

    word_t mem [word_t];
    word_t seenStoreAddr[$];
    word_t seenStoreData[$];

    clockGen clockGen_i (
        .resetRequest(resetRequest),
        .clk(clk),
        .reset(reset)
    );

    mipsBus mipsBus_i (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitRequest(waitRequest),
        .writeData(writeData), .byteEnable(byteEnable), .readData(readData)
    );

    function automatic word_t readWord(input word_t addr);
        // Unloaded words still differ per address
        return mem.exists(addr) ? mem[addr] : (addr ^ 32'h5A5AA5A5);
    endfunction

    initial begin
        waitRequest = 1'b0;
        void'($urandom(65377));
        forever begin
            @(posedge clk);
            waitRequest <= stallMode && ($urandom_range(3) == 0);
        end
    end

    // Memory model
    always @(posedge clk) begin
        if (!reset) begin
            if (read && address == `MIPS_HALT_ADDRESS) begin
                errorCount++;
                $display("error: the core issued a read to the halt address");
            end
            if (read && !waitRequest) begin
                readData <= readWord(address);
            end
            if (write && !waitRequest) begin
                mem[address] = writeData;
                seenStoreAddr.push_back(address);
                seenStoreData.push_back(writeData);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            errorCount++;
            $display("error: run did not finish within %0d cycles", cycleLimit);
            endRun();
        end
    end

    task automatic endRun();
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compareAddress(input string name, input word_t expected,
                                  input word_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s address: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic loadStimulus(output bit ok);
        int fd;
        int n;
        string kind;
        string name;
        string rest;
        word_t a;
        word_t d;
        ok = 1'b0;
        fd = $fopen("tests/mipsBus_stim.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", kind);
                if (n != 1) break;
                if (kind.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else if (kind == "M") begin
                    void'($fscanf(fd, "%h %h", a, d));
                    memTest.push_back(testNames.size());
                    memAddr.push_back(a);
                    memData.push_back(d);
                end else if (kind == "S") begin
                    void'($fscanf(fd, "%s %h %h", name, a, d));
                    storeTest.push_back(testNames.size());
                    storeAddr.push_back(a);
                    storeData.push_back(d);
                end else if (kind == "V") begin
                    // The v0 line closes a test
                    void'($fscanf(fd, "%s %h", name, d));
                    testNames.push_back(name);
                    expectedV0.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runTest(input int t, input bit stalls);
        string name;
        int errorsBefore;
        int k;
        name = stalls ? {testNames[t], "_stall"} : testNames[t];
        errorsBefore = errorCount;
        mem.delete();
        foreach (memTest[i]) begin
            if (memTest[i] == t) begin
                mem[memAddr[i]] = memData[i];
            end
        end
        seenStoreAddr.delete();
        seenStoreData.delete();

        @(posedge clk);
        resetRequest <= 1'b1;
        stallMode <= stalls;
        @(posedge clk);
        resetRequest <= 1'b0;

        // First edge the core runs on
        @(posedge clk iff !reset);
        if (active !== 1'b1 || write !== 1'b0 || read !== 1'b1) begin
            errorCount++;
            $display("error: %s did not start with active and a fetch read", name);
        end
        if (byteEnable !== 4'b1111) begin
            errorCount++;
            $display("error: %s first fetch lacks all byte enables", name);
        end
        compareAddress(name, `MIPS_RESET_VECTOR, address);

        while (active) @(posedge clk);
        repeat (QuietCycles) begin
            @(posedge clk);
            if (read || write) begin
                errorCount++;
                $display("error: %s saw bus activity after halt", name);
            end
        end

        compareWord(name, expectedV0[t], registerV0);
        k = 0;
        foreach (storeTest[i]) begin
            if (storeTest[i] == t) begin
                if (k < seenStoreAddr.size()) begin
                    compareAddress(name, storeAddr[i], seenStoreAddr[k]);
                    compareWord(name, storeData[i], seenStoreData[k]);
                end
                k++;
            end
        end
        if (k != seenStoreAddr.size()) begin
            errorCount++;
            $display("error: %s expected %0d stores but saw %0d", name, k, seenStoreAddr.size());
        end

        testsRun++;
        if (errorCount != errorsBefore) begin
            testsFailed++;
        end
        $display("%s: %s", name, (errorCount == errorsBefore) ? "ok" : "failed");
    endtask

    initial begin
        bit loaded;
        loadStimulus(loaded);
        if (!loaded) begin
            errorCount++;
            $display("error: could not read the stimulus file");
        end else begin
            // Two passes, five cycles per word, four times for stalls
            cycleLimit = 2 * (memAddr.size() * 5 * 4 + testNames.size()
                * (QuietCycles + ResetOverhead));
            for (int pass = 0; pass < 2; pass++) begin
                for (int t = 0; t < testNames.size(); t++) begin
                    runTest(t, pass == 1);
                end
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        endRun();
    end

endmodule

// File: mipsBus.f
+incdir+include
source/mipsPkg.sv
source/mipsRegisterFile.sv
source/mipsAlu.sv
source/mipsDecoder.sv
source/mipsControl.sv
source/mipsBus.sv
tests/clockGen.sv
tests/mipsBusTb.sv

// File: Bender.yml
package:
  name: mipsBus

sources:
  - include_dirs:
      - include
    files:
      - source/mipsPkg.sv
      - source/mipsRegisterFile.sv
      - source/mipsAlu.sv
      - source/mipsDecoder.sv
      - source/mipsControl.sv
      - source/mipsBus.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/clockGen.sv
      - tests/mipsBusTb.sv

// File: tests/mipsBus_stim.txt
# M address data | S test address data (expected store) | V test v0
# A V line closes the test whose M and S lines come before it
M BFC00000 3C081234
M BFC00004 35088765
M BFC00008 2409FFFD
M BFC0000C 00095043
M BFC00010 00085902
M BFC00014 016A5826
M BFC00018 0120602A
M BFC0001C 0120682B
M BFC00020 018B7004
M BFC00024 01CC1023
M BFC00028 00000008
M BFC0002C 00000000
V alu FDB96F0F
M 00001000 CAFEF00D
M BFC00000 24081000
M BFC00004 24090055
M BFC00008 AD090004
M BFC0000C 8D0A0000
M BFC00010 AD0A0008
M BFC00014 8D0B0004
M BFC00018 014B1021
M BFC0001C 00000008
M BFC00020 00000000
S memory 00001004 00000055
S memory 00001008 CAFEF00D
V memory CAFEF062
M BFC00000 24080001
M BFC00004 11000002
M BFC00008 24020010
M BFC0000C 15000003
M BFC00010 24420001
M BFC00014 24420100
M BFC00018 24420200
M BFC0001C 10000002
M BFC00020 24420002
M BFC00024 24420400
M BFC00028 0BF0000E
M BFC0002C 24420004
M BFC00030 24420800
M BFC00034 24421000
M BFC00038 3C09BFC0
M BFC0003C 3529004C
M BFC00040 01200008
M BFC00044 24420008
M BFC00048 24422000
M BFC0004C 00000008
M BFC00050 00000000
V branch 0000001F
